//--- hdl/sgb_loader_pkg.sv
package sgb_loader_pkg;

	// ================================================
	// Download stream
	// ================================================

	// Byte address, data word and slot index from the host
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	typedef logic [7:0]  ioctl_index_t;

	// Slot numbers, compared against index bits 5:0
	// Index 0 is a Game Boy cartridge as well
	localparam logic [5:0] IDX_GB_CART  = 6'd1;
	localparam logic [5:0] IDX_SGB_BIOS = 6'd4;
	localparam logic [5:0] IDX_SGB_BOOT = 6'd5;

	// Set in the address of a 512 KB SGB2 BIOS
	localparam int SGB2_ADDR_BIT = 18;

	// Flags, address, compare, replace from the top down
	typedef logic [127:0] cheat_code_t;

	// ================================================
	// Sector port and backup RAM
	// ================================================

	typedef logic [31:0] sd_lba_t;
	typedef logic [7:0]  block_t;
	typedef logic [7:0]  buff_addr_t;

	// Block index followed by the buffer word address
	typedef logic [16:0] bk_addr_t;

	typedef logic [63:0] img_size_t;

	// ================================================
	// RTC sector
	// ================================================

	typedef logic [31:0] rtc_stamp_t;
	typedef logic [47:0] rtc_saved_t;

	// Words 0-1 timestamp, words 2-4 saved time
	localparam int RTC_WORDS = 5;

	// Everything past the RTC words reads back as this
	localparam ioctl_data_t FILL_WORD = '1;

endpackage

//--- hdl/download_if.sv
`timescale 1ns/10ps

interface download_if;
	import sgb_loader_pkg::*;

	// Raw stream, qualified by ioctl_wr
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;
	logic        ioctl_wr;

	// Classified kinds
	logic        gb_cart_download;
	logic        code_download;

	// One-cycle pulses around a cartridge download
	logic        gb_load_start;
	logic        gb_load_end;

	modport source (
		output ioctl_addr, ioctl_dout, ioctl_wr,
		output gb_cart_download, code_download,
		output gb_load_start, gb_load_end
	);

	modport sink (
		input ioctl_addr, ioctl_dout, ioctl_wr,
		input gb_cart_download, code_download,
		input gb_load_start, gb_load_end
	);

endinterface

//--- hdl/load_decoder.sv
`timescale 1ns/10ps

module load_decoder (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         ioctl_download,
	input  sgb_loader_pkg::ioctl_index_t ioctl_index,
	input  sgb_loader_pkg::ioctl_addr_t  ioctl_addr,
	input  sgb_loader_pkg::ioctl_data_t  ioctl_dout,
	input  logic                         ioctl_wr,
	output logic                         cart_download,
	output logic                         gb_cart_download,
	output logic                         boot_download,
	output logic                         is_sgb2_bios,
	download_if.source                   dl
);
	import sgb_loader_pkg::*;

	logic code_download;
	logic gb_dl_q;
	logic load_start;
	logic load_end;

	// ================================================
	// Slot classification
	// ================================================

	// Cheat codes come in on the all-ones slot
	assign code_download    = ioctl_download & (&ioctl_index);
	assign cart_download    = ioctl_download & (ioctl_index[5:0] == IDX_SGB_BIOS);
	assign boot_download    = ioctl_download & (ioctl_index[5:0] == IDX_SGB_BOOT);
	assign gb_cart_download = ioctl_download &
		((ioctl_index[5:0] == IDX_GB_CART) || (ioctl_index == '0));

	// Edges of the cartridge download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gb_dl_q    <= 1'b0;
			load_start <= 1'b0;
			load_end   <= 1'b0;
			is_sgb2_bios <= 1'b0;
		end else begin
			gb_dl_q    <= gb_cart_download;
			load_start <= gb_cart_download & ~gb_dl_q;
			load_end   <= ~gb_cart_download & gb_dl_q;
			// 512 KB image reaches past bit 18, 256 KB never does
			if (cart_download & ioctl_wr)
				is_sgb2_bios <= ioctl_addr[SGB2_ADDR_BIT];
		end
	end

	// Stream out to the consumers
	assign dl.ioctl_addr       = ioctl_addr;
	assign dl.ioctl_dout       = ioctl_dout;
	assign dl.ioctl_wr         = ioctl_wr;
	assign dl.gb_cart_download = gb_cart_download;
	assign dl.code_download    = code_download;
	assign dl.gb_load_start    = load_start;
	assign dl.gb_load_end      = load_end;

endmodule

//--- hdl/cheat_code_assembler.sv
`timescale 1ns/10ps

module cheat_code_assembler (
	input  logic                        clk_sys,
	input  logic                        RESET,
	download_if.sink                    dl,
	output sgb_loader_pkg::cheat_code_t cheat_code,
	output logic                        gg_code_strobe,
	output logic                        gg_reset
);
	import sgb_loader_pkg::*;

	logic code_wr;

	assign code_wr = dl.code_download & dl.ioctl_wr;

	// Word slots, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= dl.ioctl_dout;
				4'd2:  cheat_code[127:112] <= dl.ioctl_dout;
				4'd4:  cheat_code[79:64]   <= dl.ioctl_dout;
				4'd6:  cheat_code[95:80]   <= dl.ioctl_dout;
				4'd8:  cheat_code[47:32]   <= dl.ioctl_dout;
				4'd10: cheat_code[63:48]   <= dl.ioctl_dout;
				4'd12: cheat_code[15:0]    <= dl.ioctl_dout;
				4'd14: cheat_code[31:16]   <= dl.ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of the code in, hand it over
	always_ff @(posedge clk_sys) begin
		if (RESET)
			gg_code_strobe <= 1'b0;
		else
			gg_code_strobe <= code_wr & (dl.ioctl_addr[3:0] == 4'd14);
	end

	// Code list restarts at address 0, new cartridge drops all codes
	assign gg_reset = (code_wr && (dl.ioctl_addr == '0)) || dl.gb_cart_download;

	// Host never writes offset 14 twice in a row
	a_strobe_single: assert property (
		@(posedge clk_sys) disable iff (RESET)
		gg_code_strobe |=> !gg_code_strobe
	) else $error("gg_code_strobe held for more than one cycle");

endmodule

//--- hdl/backup_sequencer.sv
`timescale 1ns/10ps

module backup_sequencer (
	input  logic                      clk_sys,
	input  logic                      RESET,
	download_if.sink                  dl,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  sgb_loader_pkg::img_size_t img_size,
	input  logic                      cart_has_save,
	input  logic                      rtc_inuse,
	input  sgb_loader_pkg::block_t    ram_mask,
	input  logic                      load_req,
	input  logic                      save_req,
	input  logic                      autosave,
	input  logic                      osd_status,
	input  logic                      cram_wr,
	input  logic                      sd_ack,
	output sgb_loader_pkg::sd_lba_t   sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic                      bk_busy,
	output logic                      bk_loading,
	output logic                      sav_pending,
	output logic                      sav_supported,
	output sgb_loader_pkg::block_t    block,
	output logic                      rtc_block
);
	import sgb_loader_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_XFER
	} bk_state_t;

	bk_state_t state;
	logic      bk_ena;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      save_trig;
	logic      load_start;
	logic      save_start;
	logic      xfer_start;
	logic      last_block;

	// ================================================
	// Triggers
	// ================================================

	// Autosave waits until the OSD is opened
	assign save_trig  = save_req | (sav_pending & osd_status & autosave);
	assign load_start = bk_ena & ((load_req & ~load_q) | (dl.gb_load_end & (|img_size)));
	assign save_start = bk_ena & save_trig & ~save_q;
	assign xfer_start = (state == ST_IDLE) & (load_start | save_start);

	assign sav_supported = cart_has_save & bk_ena;

	// Save file is mounted while the cartridge is still downloading
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else begin
			if (dl.gb_load_start)
				bk_ena <= 1'b0;
			if (dl.gb_cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// Game wrote cartridge RAM outside the menu
	always_ff @(posedge clk_sys) begin
		if (RESET)
			sav_pending <= 1'b0;
		else if (cram_wr & ~osd_status & sav_supported)
			sav_pending <= 1'b1;
		else if (xfer_start | ~bk_ena)
			sav_pending <= 1'b0;
	end

	// ================================================
	// Sector FSM
	// ================================================

	assign block     = sd_lba[7:0];
	assign rtc_block = block > ram_mask;

	// One extra sector carries the RTC words
	assign last_block = rtc_inuse ? rtc_block : (block >= ram_mask);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= ST_IDLE;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_trig;
			ack_q  <= sd_ack;

			// Host took the request
			if (~ack_q & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (xfer_start) begin
						state      <= ST_XFER;
						bk_loading <= load_start;
						sd_lba     <= '0;
						sd_rd      <= load_start;
						sd_wr      <= ~load_start;
					end
				end
				ST_XFER: begin
					// Sector done on falling ack
					if (ack_q & ~sd_ack) begin
						if (last_block) begin
							state      <= ST_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + sd_lba_t'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign bk_busy = (state == ST_XFER);

	a_rd_wr_excl: assert property (
		@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr)
	) else $error("sd_rd and sd_wr high together");

	a_req_busy: assert property (
		@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |-> bk_busy
	) else $error("sector request outside a transfer");

endmodule

//--- hdl/backup_block_router.sv
`timescale 1ns/10ps

module backup_block_router (
	input  sgb_loader_pkg::block_t      block,
	input  logic                        rtc_block,
	input  sgb_loader_pkg::buff_addr_t  sd_buff_addr,
	input  sgb_loader_pkg::ioctl_data_t sd_buff_dout,
	input  logic                        sd_buff_wr,
	input  logic                        sd_ack,
	input  sgb_loader_pkg::ioctl_data_t bk_q,
	input  sgb_loader_pkg::rtc_stamp_t  rtc_timestamp,
	input  sgb_loader_pkg::rtc_saved_t  rtc_savedtime,
	output sgb_loader_pkg::ioctl_data_t sd_buff_din,
	output sgb_loader_pkg::bk_addr_t    bk_addr,
	output sgb_loader_pkg::ioctl_data_t bk_data,
	output logic                        bk_wr,
	output logic                        bk_rtc_wr
);
	import sgb_loader_pkg::*;

	// Loads land in backup RAM, or in the RTC when past ram_mask
	assign bk_addr   = bk_addr_t'({block, sd_buff_addr});
	assign bk_data   = sd_buff_dout;
	assign bk_wr     = sd_buff_wr & sd_ack & ~rtc_block;
	assign bk_rtc_wr = sd_buff_wr & sd_ack & rtc_block;

	// Save data, RTC sector built from the two time words
	always_comb begin
		if (!rtc_block) begin
			sd_buff_din = bk_q;
		end else if (sd_buff_addr >= buff_addr_t'(RTC_WORDS)) begin
			sd_buff_din = FILL_WORD;
		end else begin
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc_timestamp[15:0];
				8'd1:    sd_buff_din = rtc_timestamp[31:16];
				8'd2:    sd_buff_din = rtc_savedtime[15:0];
				8'd3:    sd_buff_din = rtc_savedtime[31:16];
				8'd4:    sd_buff_din = rtc_savedtime[47:32];
				default: sd_buff_din = FILL_WORD;
			endcase
		end
	end

endmodule

//--- hdl/sgb_loader_top.sv
`timescale 1ns/10ps

module sgb_loader_top (
	input  logic                         clk_sys,
	input  logic                         RESET,
	// Host download
	input  logic                         ioctl_download,
	input  sgb_loader_pkg::ioctl_index_t ioctl_index,
	input  sgb_loader_pkg::ioctl_addr_t  ioctl_addr,
	input  sgb_loader_pkg::ioctl_data_t  ioctl_dout,
	input  logic                         ioctl_wr,
	// Image and save control
	input  logic                         img_mounted,
	input  logic                         img_readonly,
	input  sgb_loader_pkg::img_size_t    img_size,
	input  logic                         cart_has_save,
	input  logic                         rtc_inuse,
	input  sgb_loader_pkg::block_t       ram_mask,
	input  logic                         load_req,
	input  logic                         save_req,
	input  logic                         autosave,
	input  logic                         osd_status,
	input  logic                         cram_wr,
	// Sector port
	output sgb_loader_pkg::sd_lba_t      sd_lba,
	output logic                         sd_rd,
	output logic                         sd_wr,
	input  logic                         sd_ack,
	input  sgb_loader_pkg::buff_addr_t   sd_buff_addr,
	input  sgb_loader_pkg::ioctl_data_t  sd_buff_dout,
	output sgb_loader_pkg::ioctl_data_t  sd_buff_din,
	input  logic                         sd_buff_wr,
	// Backup RAM and RTC
	output sgb_loader_pkg::bk_addr_t     bk_addr,
	output sgb_loader_pkg::ioctl_data_t  bk_data,
	output logic                         bk_wr,
	output logic                         bk_rtc_wr,
	input  sgb_loader_pkg::ioctl_data_t  bk_q,
	input  sgb_loader_pkg::rtc_stamp_t   rtc_timestamp,
	input  sgb_loader_pkg::rtc_saved_t   rtc_savedtime,
	// Status
	output logic                         cart_download,
	output logic                         gb_cart_download,
	output logic                         boot_download,
	output logic                         is_sgb2_bios,
	output sgb_loader_pkg::cheat_code_t  cheat_code,
	output logic                         gg_code_strobe,
	output logic                         gg_reset,
	output logic                         bk_busy,
	output logic                         bk_loading,
	output logic                         sav_pending,
	output logic                         sav_supported
);
	import sgb_loader_pkg::*;

	block_t block;
	logic   rtc_block;

	download_if dl_bus ();

	load_decoder u_decoder (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.ioctl_wr         (ioctl_wr),
		.cart_download    (cart_download),
		.gb_cart_download (gb_cart_download),
		.boot_download    (boot_download),
		.is_sgb2_bios     (is_sgb2_bios),
		.dl               (dl_bus.source)
	);

	cheat_code_assembler u_cheat (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl             (dl_bus.sink),
		.cheat_code     (cheat_code),
		.gg_code_strobe (gg_code_strobe),
		.gg_reset       (gg_reset)
	);

	backup_sequencer u_sequencer (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl_bus.sink),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.cart_has_save (cart_has_save),
		.rtc_inuse     (rtc_inuse),
		.ram_mask      (ram_mask),
		.load_req      (load_req),
		.save_req      (save_req),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.cram_wr       (cram_wr),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.sav_pending   (sav_pending),
		.sav_supported (sav_supported),
		.block         (block),
		.rtc_block     (rtc_block)
	);

	backup_block_router u_router (
		.block         (block),
		.rtc_block     (rtc_block),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_ack        (sd_ack),
		.bk_q          (bk_q),
		.rtc_timestamp (rtc_timestamp),
		.rtc_savedtime (rtc_savedtime),
		.sd_buff_din   (sd_buff_din),
		.bk_addr       (bk_addr),
		.bk_data       (bk_data),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr)
	);

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Released on a rising edge
	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		RESET <= 1'b0;
	end

endmodule

//--- bench/tb_sgb_loader.sv
`timescale 1ns/10ps

module tb_sgb_loader;
	import sgb_loader_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int SEED           = 14060;
	// Three transfers of up to four sectors at about 13 cycles each, plus download tests
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int START_LIMIT    = 20;
	localparam int SECTOR_WORDS   = 8;

	logic         clk_sys;
	logic         RESET;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr;
	ioctl_data_t  ioctl_dout;
	logic         ioctl_wr;
	logic         img_mounted;
	logic         img_readonly;
	img_size_t    img_size;
	logic         cart_has_save;
	logic         rtc_inuse;
	block_t       ram_mask;
	logic         load_req;
	logic         save_req;
	logic         autosave;
	logic         osd_status;
	logic         cram_wr;
	sd_lba_t      sd_lba;
	logic         sd_rd;
	logic         sd_wr;
	logic         sd_ack;
	buff_addr_t   sd_buff_addr;
	ioctl_data_t  sd_buff_dout;
	ioctl_data_t  sd_buff_din;
	logic         sd_buff_wr;
	bk_addr_t     bk_addr;
	ioctl_data_t  bk_data;
	logic         bk_wr;
	logic         bk_rtc_wr;
	ioctl_data_t  bk_q;
	rtc_stamp_t   rtc_timestamp;
	rtc_saved_t   rtc_savedtime;
	logic         cart_download;
	logic         gb_cart_download;
	logic         boot_download;
	logic         is_sgb2_bios;
	cheat_code_t  cheat_code;
	logic         gg_code_strobe;
	logic         gg_reset;
	logic         bk_busy;
	logic         bk_loading;
	logic         sav_pending;
	logic         sav_supported;

	int errors      = 0;
	int cycle_count = 0;

	// One entry per sector, then one per word
	sd_lba_t     sec_lba[$];
	logic        sec_load[$];
	ioctl_data_t w_dout[$];
	ioctl_data_t w_din[$];
	bk_addr_t    w_bk_addr[$];
	ioctl_data_t w_bk_data[$];
	logic        w_bk_wr[$];
	logic        w_rtc_wr[$];

	tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clk (
		.clk_sys (clk_sys),
		.RESET   (RESET)
	);

	sgb_loader_top dut0 (.*);

	// ================================================
	// Compare tasks
	// ================================================

	task automatic compare_code(input string name, input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_data(input string name, input ioctl_data_t got, input ioctl_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_lba(input string name, input sd_lba_t got, input sd_lba_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input bk_addr_t got, input bk_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_logic(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ================================================
	// Sector port model
	// ================================================

	// Ack two cycles after a request, one buffer word per cycle while ack is high
	initial begin : sector_port
		sd_lba_t lba;
		logic    load_dir;
		int      i;
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		forever begin
			@(posedge clk_sys);
			if (!RESET && (sd_rd || sd_wr)) begin
				lba      = sd_lba;
				load_dir = sd_rd;
				sec_lba.push_back(lba);
				sec_load.push_back(load_dir);
				@(posedge clk_sys);
				sd_ack <= 1'b1;
				for (i = 0; i <= SECTOR_WORDS; i++) begin
					@(posedge clk_sys);
					// Values seen for the word driven on the previous edge
					if (i > 0) begin
						w_dout.push_back(sd_buff_dout);
						w_din.push_back(sd_buff_din);
						w_bk_addr.push_back(bk_addr);
						w_bk_data.push_back(bk_data);
						w_bk_wr.push_back(bk_wr);
						w_rtc_wr.push_back(bk_rtc_wr);
					end
					if (i < SECTOR_WORDS) begin
						sd_buff_addr <= buff_addr_t'(i);
						sd_buff_dout <= ioctl_data_t'($urandom);
						sd_buff_wr   <= load_dir;
					end else begin
						sd_buff_wr <= 1'b0;
						sd_ack     <= 1'b0;
					end
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("Errors: %0d", errors);
			$display("Test failed");
			$finish;
		end
	end

	// ================================================
	// Helpers
	// ================================================

	task automatic wait_transfer(input string kind, input logic loading);
		int n;
		n = 0;
		while (!bk_busy && n < START_LIMIT) begin
			@(posedge clk_sys);
			n++;
		end
		if (!bk_busy) begin
			errors++;
			$display("No %s transfer started within %0d cycles", kind, START_LIMIT);
		end else begin
			compare_logic("bk_loading", bk_loading, loading);
			while (bk_busy)
				@(posedge clk_sys);
		end
	endtask

	// Sectors 0 upward, RTC sector is any one past mask
	task automatic check_sectors(input int sb, input int wb, input int n, input logic load,
			input int mask);
		int           s;
		int           a;
		int           j;
		logic         rtc;
		logic [127:0] rtc_img;
		ioctl_data_t  exp;
		rtc_img = {{3{16'hFFFF}}, rtc_savedtime, rtc_timestamp};
		if (sec_lba.size() - sb != n) begin
			errors++;
			$display("Wrong sector count: %0d moved, %0d expected", sec_lba.size() - sb, n);
		end else begin
			for (s = 0; s < n; s++) begin
				rtc = (s > mask);
				compare_lba("sd_lba", sec_lba[sb + s], sd_lba_t'(s));
				compare_logic("sd_rd", sec_load[sb + s], load);
				for (a = 0; a < SECTOR_WORDS; a++) begin
					j = wb + s * SECTOR_WORDS + a;
					if (load) begin
						compare_logic("bk_wr", w_bk_wr[j], !rtc);
						compare_logic("bk_rtc_wr", w_rtc_wr[j], rtc);
						compare_addr("bk_addr", w_bk_addr[j],
							bk_addr_t'({block_t'(s), buff_addr_t'(a)}));
						compare_data("bk_data", w_bk_data[j], w_dout[j]);
					end else begin
						exp = rtc ? rtc_img[a * 16 +: 16] : bk_q;
						compare_data("sd_buff_din", w_din[j], exp);
					end
				end
			end
		end
	endtask

	// ================================================
	// Tests
	// ================================================

	task automatic test_classify;
		ioctl_index_t idx [4];
		int           k;
		idx = '{8'd0, 8'd1, 8'd4, 8'd5};
		for (k = 0; k < 4; k++) begin
			@(posedge clk_sys);
			ioctl_index    <= idx[k];
			ioctl_download <= 1'b1;
			@(negedge clk_sys);
			compare_logic("cart_download", cart_download, idx[k] == 8'd4);
			compare_logic("gb_cart_download", gb_cart_download, idx[k] <= 8'd1);
			compare_logic("boot_download", boot_download, idx[k] == 8'd5);
			compare_logic("gg_reset", gg_reset, idx[k] <= 8'd1);
			@(posedge clk_sys);
			ioctl_download <= 1'b0;
			@(negedge clk_sys);
			compare_logic("cart_download", cart_download, 1'b0);
			compare_logic("gb_cart_download", gb_cart_download, 1'b0);
			compare_logic("boot_download", boot_download, 1'b0);
		end
		// BIOS write with bit 18 set, then one with it clear
		@(posedge clk_sys);
		ioctl_index    <= 8'd4;
		ioctl_download <= 1'b1;
		ioctl_addr     <= 25'h40000;
		ioctl_wr       <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		compare_logic("is_sgb2_bios", is_sgb2_bios, 1'b1);
		@(posedge clk_sys);
		ioctl_addr <= 25'h00100;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		compare_logic("is_sgb2_bios", is_sgb2_bios, 1'b0);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic test_cheat_code;
		ioctl_data_t w [8];
		cheat_code_t exp;
		int          k;
		@(posedge clk_sys);
		ioctl_index    <= 8'hFF;
		ioctl_download <= 1'b1;
		for (k = 0; k < 8; k++) begin
			w[k] = ioctl_data_t'($urandom);
			@(posedge clk_sys);
			ioctl_addr <= ioctl_addr_t'(2 * k);
			ioctl_dout <= w[k];
			ioctl_wr   <= 1'b1;
			@(negedge clk_sys);
			compare_logic("gg_reset", gg_reset, k == 0);
			compare_logic("gg_code_strobe", gg_code_strobe, 1'b0);
		end
		// Flags, address, compare, replace with the low word of each first
		exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		compare_logic("gg_code_strobe", gg_code_strobe, 1'b1);
		compare_code("cheat_code", cheat_code, exp);
		compare_logic("gg_reset", gg_reset, 1'b0);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(negedge clk_sys);
		compare_logic("gg_code_strobe", gg_code_strobe, 1'b0);
	endtask

	task automatic test_auto_load;
		int sb;
		int wb;
		@(posedge clk_sys);
		ram_mask       <= block_t'(2);
		rtc_inuse      <= 1'b1;
		img_size       <= 64'h8000;
		img_readonly   <= 1'b0;
		cart_has_save  <= 1'b1;
		ioctl_index    <= 8'd1;
		ioctl_download <= 1'b1;
		repeat (3) @(posedge clk_sys);
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		repeat (2) @(posedge clk_sys);
		sb = sec_lba.size();
		wb = w_din.size();
		ioctl_download <= 1'b0;
		wait_transfer("load", 1'b1);
		check_sectors(sb, wb, 4, 1'b1, 2);
		@(negedge clk_sys);
		compare_logic("sav_supported", sav_supported, 1'b1);
	endtask

	task automatic test_save;
		int sb;
		int wb;
		@(posedge clk_sys);
		rtc_timestamp <= rtc_stamp_t'($urandom);
		rtc_savedtime <= rtc_saved_t'({ioctl_data_t'($urandom), $urandom});
		bk_q          <= ioctl_data_t'($urandom);
		sb = sec_lba.size();
		wb = w_din.size();
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		wait_transfer("save", 1'b0);
		check_sectors(sb, wb, 4, 1'b0, 2);
	endtask

	task automatic test_autosave;
		int sb;
		int wb;
		@(posedge clk_sys);
		rtc_inuse  <= 1'b0;
		autosave   <= 1'b1;
		osd_status <= 1'b0;
		cram_wr    <= 1'b1;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		compare_logic("sav_pending", sav_pending, 1'b1);
		@(posedge clk_sys);
		sb = sec_lba.size();
		wb = w_din.size();
		osd_status <= 1'b1;
		wait_transfer("autosave", 1'b0);
		@(negedge clk_sys);
		compare_logic("sav_pending", sav_pending, 1'b0);
		check_sectors(sb, wb, 3, 1'b0, 2);
		// No save support, so nothing may start
		@(posedge clk_sys);
		osd_status    <= 1'b0;
		cart_has_save <= 1'b0;
		@(posedge clk_sys);
		cram_wr <= 1'b1;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		compare_logic("sav_supported", sav_supported, 1'b0);
		compare_logic("sav_pending", sav_pending, 1'b0);
		@(posedge clk_sys);
		sb = sec_lba.size();
		osd_status <= 1'b1;
		repeat (START_LIMIT) @(posedge clk_sys);
		if (bk_busy || sec_lba.size() != sb) begin
			errors++;
			$display("A save started although the cartridge has no save support");
		end
		osd_status <= 1'b0;
		autosave   <= 1'b0;
	endtask

	// ================================================
	// Main sequence
	// ================================================

	initial begin : main
		void'($urandom(SEED));
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		cart_has_save  = 1'b0;
		rtc_inuse      = 1'b0;
		ram_mask       = '0;
		load_req       = 1'b0;
		save_req       = 1'b0;
		autosave       = 1'b0;
		osd_status     = 1'b0;
		cram_wr        = 1'b0;
		bk_q           = '0;
		rtc_timestamp  = '0;
		rtc_savedtime  = '0;

		while (RESET !== 1'b0)
			@(posedge clk_sys);
		@(negedge clk_sys);
		compare_logic("sd_rd", sd_rd, 1'b0);
		compare_logic("sd_wr", sd_wr, 1'b0);
		compare_logic("gg_code_strobe", gg_code_strobe, 1'b0);
		compare_logic("bk_busy", bk_busy, 1'b0);
		compare_logic("bk_loading", bk_loading, 1'b0);
		compare_logic("sav_pending", sav_pending, 1'b0);
		compare_logic("sav_supported", sav_supported, 1'b0);

		test_classify();
		test_cheat_code();
		test_auto_load();
		test_save();
		test_autosave();

		repeat (2) @(posedge clk_sys);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- files.f
hdl/sgb_loader_pkg.sv
hdl/download_if.sv
hdl/load_decoder.sv
hdl/cheat_code_assembler.sv
hdl/backup_sequencer.sv
hdl/backup_block_router.sv
hdl/sgb_loader_top.sv
bench/tb_clk_gen.sv
bench/tb_sgb_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_sgb_loader \
	--Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi

exit 0
